// File: design/dcache_pkg.sv
/* Data cache shared definitions */

`default_nettype none

package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W   = 16;
    localparam int XLEN     = 32;
    localparam int BLOCK_W  = 128;
    localparam int DEPTH    = 16;

    // Address split into tag, index, word select and byte
    localparam int OFFSET_W = $clog2(BLOCK_W / 8);
    localparam int WSEL_W   = $clog2(BLOCK_W / XLEN);
    localparam int INDEX_W  = $clog2(DEPTH);
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [XLEN-1:0]        word_t;
    typedef logic [XLEN/8-1:0]      strb_t;
    typedef logic [BLOCK_W-1:0]     block_t;
    typedef logic [BLOCK_W/8-1:0]   bstrb_t;
    typedef logic [INDEX_W-1:0]     index_t;
    typedef logic [TAG_W-1:0]       tag_t;

    typedef enum logic [1:0] {RD_IDLE, RD_LOOKUP, RD_REFILL, RD_RESPOND} rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_MEMWRITE, WR_ACK} wr_state_t;

    // Everything from here up is uncached
    localparam addr_t IO_BASE = 16'hF000;

    function automatic logic is_io(input addr_t addr);
        return (addr >= IO_BASE);
    endfunction

endpackage

`default_nettype wire

// File: design/dcache_blocks.sv
/* Cache block storage */

`timescale 1ns/1ps
`default_nettype none

module dcache_blocks (
    input  wire                        aclk,
    input  wire                        rst_n,
    // Lookup port 1 for the read path
    input  wire  dcache_pkg::index_t   p1_index,
    input  wire  dcache_pkg::tag_t     p1_tag,
    output logic                       p1_hit,
    output dcache_pkg::block_t         p1_data,
    // Lookup port 2 for the write path
    input  wire  dcache_pkg::index_t   p2_index,
    input  wire  dcache_pkg::tag_t     p2_tag,
    output logic                       p2_hit,
    // Whole block refill
    input  wire                        refill_en,
    input  wire  dcache_pkg::index_t   refill_index,
    input  wire  dcache_pkg::tag_t     refill_tag,
    input  wire  dcache_pkg::block_t   refill_data,
    // Byte strobed update
    input  wire                        upd_en,
    input  wire  dcache_pkg::index_t   upd_index,
    input  wire  dcache_pkg::block_t   upd_data,
    input  wire  dcache_pkg::bstrb_t   upd_strb
);

    logic [dcache_pkg::DEPTH-1:0] valid;
    dcache_pkg::tag_t             tag_mem  [0:dcache_pkg::DEPTH-1];
    dcache_pkg::block_t           data_mem [0:dcache_pkg::DEPTH-1];

    //////////////////////////////////////////////////////////////////////
    // Combinational lookup on both ports
    //////////////////////////////////////////////////////////////////////

    assign p1_hit  = valid[p1_index] && (tag_mem[p1_index] == p1_tag);
    assign p1_data = data_mem[p1_index];

    assign p2_hit  = valid[p2_index] && (tag_mem[p2_index] == p2_tag);

    //////////////////////////////////////////////////////////////////////
    // Storage writes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (refill_en) begin
            valid[refill_index] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (refill_en) begin
            tag_mem[refill_index]  <= refill_tag;
            data_mem[refill_index] <= refill_data;
        end else if (upd_en && valid[upd_index]) begin
            // Only the strobed bytes of the line change
            for (int i = 0; i < dcache_pkg::BLOCK_W / 8; i++) begin
                if (upd_strb[i]) begin
                    data_mem[upd_index][8*i +: 8] <= upd_data[8*i +: 8];
                end
            end
        end
    end

    // Reader and writer are kept apart by the busy flags
    refill_upd_exclusive: assert property (
        @(posedge aclk) disable iff (!rst_n) !(refill_en && upd_en)
    );

endmodule

`default_nettype wire

// File: design/dcache_reader.sv
/* Data cache read path */

`timescale 1ns/1ps
`default_nettype none

module dcache_reader (
    input  wire                        aclk,
    input  wire                        rst_n,
    // Core read request
    input  wire                        rd_valid,
    output logic                       rd_ready,
    input  wire  dcache_pkg::addr_t    rd_addr,
    // Core read response
    output logic                       rsp_valid,
    input  wire                        rsp_ready,
    output dcache_pkg::word_t          rsp_data,
    // Memory block read
    output logic                       mem_arvalid,
    input  wire                        mem_arready,
    output dcache_pkg::addr_t          mem_araddr,
    input  wire                        mem_rvalid,
    output logic                       mem_rready,
    input  wire  dcache_pkg::block_t   mem_rdata,
    // Ordering between reads and writes
    input  wire                        wr_busy,
    output logic                       rd_busy,
    // Storage
    output dcache_pkg::index_t         p1_index,
    output dcache_pkg::tag_t           p1_tag,
    input  wire                        p1_hit,
    input  wire  dcache_pkg::block_t   p1_data,
    output logic                       refill_en,
    output dcache_pkg::index_t         refill_index,
    output dcache_pkg::tag_t           refill_tag,
    output dcache_pkg::block_t         refill_data
);

    dcache_pkg::rd_state_t                state;
    dcache_pkg::addr_t                    addr_q;
    dcache_pkg::addr_t                    lookup_addr;
    logic [dcache_pkg::WSEL_W-1:0]        wsel;
    dcache_pkg::block_t                   src_block;
    dcache_pkg::word_t                    sel_word;
    logic                                 rd_accept;
    logic                                 r_done;

    assign rd_ready  = (state == dcache_pkg::RD_IDLE) && !wr_busy;
    assign rd_accept = rd_valid && rd_ready;
    // A pending request already counts, so a write arriving with it loses
    assign rd_busy   = (state != dcache_pkg::RD_IDLE) || rd_valid;

    //////////////////////////////////////////////////////////////////////
    // Lookup and word select
    //////////////////////////////////////////////////////////////////////

    // Incoming address while idle, so a miss is known at acceptance
    assign lookup_addr = (state == dcache_pkg::RD_IDLE) ? rd_addr : addr_q;
    assign p1_index    = lookup_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign p1_tag      = lookup_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];

    assign wsel      = addr_q[dcache_pkg::OFFSET_W-1 -: dcache_pkg::WSEL_W];
    assign src_block = (state == dcache_pkg::RD_LOOKUP) ? p1_data : mem_rdata;
    assign sel_word  = src_block[wsel*dcache_pkg::XLEN +: dcache_pkg::XLEN];

    //////////////////////////////////////////////////////////////////////
    // Memory side
    //////////////////////////////////////////////////////////////////////

    assign mem_araddr = addr_q & ~dcache_pkg::addr_t'(dcache_pkg::BLOCK_W / 8 - 1);
    // Data is taken only once the address has gone out
    assign mem_rready = (state == dcache_pkg::RD_REFILL) && !mem_arvalid;
    assign r_done     = mem_rvalid && mem_rready;

    // IO data passes through and is never installed
    assign refill_en    = r_done && !dcache_pkg::is_io(addr_q);
    assign refill_index = addr_q[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign refill_tag   = addr_q[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign refill_data  = mem_rdata;

    assign rsp_valid = (state == dcache_pkg::RD_RESPOND);

    //////////////////////////////////////////////////////////////////////
    // Read FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= dcache_pkg::RD_IDLE;
            mem_arvalid <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::RD_IDLE: begin
                    if (rd_accept) begin
                        if (dcache_pkg::is_io(rd_addr) || !p1_hit) begin
                            state       <= dcache_pkg::RD_REFILL;
                            mem_arvalid <= 1'b1;
                        end else begin
                            state <= dcache_pkg::RD_LOOKUP;
                        end
                    end
                end
                dcache_pkg::RD_LOOKUP: begin
                    state <= dcache_pkg::RD_RESPOND;
                end
                dcache_pkg::RD_REFILL: begin
                    if (mem_arvalid && mem_arready) begin
                        mem_arvalid <= 1'b0;
                    end
                    if (r_done) begin
                        state <= dcache_pkg::RD_RESPOND;
                    end
                end
                dcache_pkg::RD_RESPOND: begin
                    if (rsp_ready) begin
                        state <= dcache_pkg::RD_IDLE;
                    end
                end
                default: begin
                    state <= dcache_pkg::RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_accept) begin
            addr_q <= rd_addr;
        end
        if ((state == dcache_pkg::RD_LOOKUP) || r_done) begin
            rsp_data <= sel_word;
        end
    end

    // A block read goes out only for IO or for a line that is not resident
    araddr_only_on_miss: assert property (
        @(posedge aclk) disable iff (!rst_n)
        mem_arvalid |-> (dcache_pkg::is_io(addr_q) || !p1_hit)
    );

    rsp_held_on_stall: assert property (
        @(posedge aclk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data))
    );

endmodule

`default_nettype wire

// File: design/dcache_writer.sv
/* Data cache write-through path */

`timescale 1ns/1ps
`default_nettype none

module dcache_writer (
    input  wire                        aclk,
    input  wire                        rst_n,
    // Core write request
    input  wire                        wr_valid,
    output logic                       wr_ready,
    input  wire  dcache_pkg::addr_t    wr_addr,
    input  wire  dcache_pkg::word_t    wr_data,
    input  wire  dcache_pkg::strb_t    wr_strb,
    // Core write acknowledge
    output logic                       wack_valid,
    input  wire                        wack_ready,
    // Memory word write
    output logic                       mem_awvalid,
    input  wire                        mem_awready,
    output dcache_pkg::addr_t          mem_awaddr,
    output dcache_pkg::word_t          mem_wdata,
    output dcache_pkg::strb_t          mem_wstrb,
    // Memory write response
    input  wire                        mem_bvalid,
    output logic                       mem_bready,
    // Ordering between reads and writes
    input  wire                        rd_busy,
    output logic                       wr_busy,
    // Storage
    output dcache_pkg::index_t         p2_index,
    output dcache_pkg::tag_t           p2_tag,
    input  wire                        p2_hit,
    output logic                       upd_en,
    output dcache_pkg::index_t         upd_index,
    output dcache_pkg::block_t         upd_data,
    output dcache_pkg::bstrb_t         upd_strb
);

    dcache_pkg::wr_state_t                state;
    dcache_pkg::addr_t                    addr_q;
    dcache_pkg::word_t                    data_q;
    dcache_pkg::strb_t                    strb_q;
    logic [dcache_pkg::WSEL_W-1:0]        wsel;
    logic                                 upd_first;
    logic                                 wr_accept;

    assign wr_ready  = (state == dcache_pkg::WR_IDLE) && !rd_busy;
    assign wr_accept = wr_valid && wr_ready;
    assign wr_busy   = (state != dcache_pkg::WR_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Cache update on hit
    //////////////////////////////////////////////////////////////////////

    assign p2_index  = addr_q[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    assign p2_tag    = addr_q[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign upd_index = p2_index;

    // Word copied into every lane, strobes pick the one that counts
    assign wsel     = addr_q[dcache_pkg::OFFSET_W-1 -: dcache_pkg::WSEL_W];
    assign upd_data = {(dcache_pkg::BLOCK_W / dcache_pkg::XLEN){data_q}};
    assign upd_strb = dcache_pkg::bstrb_t'(strb_q) << (wsel * (dcache_pkg::XLEN / 8));

    // One cycle after acceptance, and only for a resident cached line
    assign upd_en = upd_first && p2_hit && !dcache_pkg::is_io(addr_q);

    //////////////////////////////////////////////////////////////////////
    // Memory side
    //////////////////////////////////////////////////////////////////////

    assign mem_awaddr = addr_q & ~dcache_pkg::addr_t'(dcache_pkg::XLEN / 8 - 1);
    assign mem_wdata  = data_q;
    assign mem_wstrb  = strb_q;
    assign mem_bready = (state == dcache_pkg::WR_MEMWRITE) && !mem_awvalid;

    assign wack_valid = (state == dcache_pkg::WR_ACK);

    //////////////////////////////////////////////////////////////////////
    // Write FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= dcache_pkg::WR_IDLE;
            mem_awvalid <= 1'b0;
            upd_first   <= 1'b0;
        end else begin
            upd_first <= wr_accept;
            case (state)
                dcache_pkg::WR_IDLE: begin
                    if (wr_accept) begin
                        state       <= dcache_pkg::WR_MEMWRITE;
                        mem_awvalid <= 1'b1;
                    end
                end
                dcache_pkg::WR_MEMWRITE: begin
                    if (mem_awvalid && mem_awready) begin
                        mem_awvalid <= 1'b0;
                    end
                    if (mem_bvalid && mem_bready) begin
                        state <= dcache_pkg::WR_ACK;
                    end
                end
                dcache_pkg::WR_ACK: begin
                    if (wack_ready) begin
                        state <= dcache_pkg::WR_IDLE;
                    end
                end
                default: begin
                    state <= dcache_pkg::WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_accept) begin
            addr_q <= wr_addr;
            data_q <= wr_data;
            strb_q <= wr_strb;
        end
    end

    wstrb_nonzero: assert property (
        @(posedge aclk) disable iff (!rst_n) mem_awvalid |-> (mem_wstrb != '0)
    );

endmodule

`default_nettype wire

// File: design/dcache_top.sv
/* Write-through data cache */

`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire                        aclk,
    input  wire                        rst_n,
    // Core side
    input  wire                        rd_valid,
    output logic                       rd_ready,
    input  wire  dcache_pkg::addr_t    rd_addr,
    output logic                       rsp_valid,
    input  wire                        rsp_ready,
    output dcache_pkg::word_t          rsp_data,
    input  wire                        wr_valid,
    output logic                       wr_ready,
    input  wire  dcache_pkg::addr_t    wr_addr,
    input  wire  dcache_pkg::word_t    wr_data,
    input  wire  dcache_pkg::strb_t    wr_strb,
    output logic                       wack_valid,
    input  wire                        wack_ready,
    // Memory side
    output logic                       mem_arvalid,
    input  wire                        mem_arready,
    output dcache_pkg::addr_t          mem_araddr,
    input  wire                        mem_rvalid,
    output logic                       mem_rready,
    input  wire  dcache_pkg::block_t   mem_rdata,
    output logic                       mem_awvalid,
    input  wire                        mem_awready,
    output dcache_pkg::addr_t          mem_awaddr,
    output dcache_pkg::word_t          mem_wdata,
    output dcache_pkg::strb_t          mem_wstrb,
    input  wire                        mem_bvalid,
    output logic                       mem_bready
);

    // Ordering flags
    logic                  rd_busy;
    logic                  wr_busy;

    // Storage ports
    dcache_pkg::index_t    p1_index;
    dcache_pkg::tag_t      p1_tag;
    logic                  p1_hit;
    dcache_pkg::block_t    p1_data;
    dcache_pkg::index_t    p2_index;
    dcache_pkg::tag_t      p2_tag;
    logic                  p2_hit;
    logic                  refill_en;
    dcache_pkg::index_t    refill_index;
    dcache_pkg::tag_t      refill_tag;
    dcache_pkg::block_t    refill_data;
    logic                  upd_en;
    dcache_pkg::index_t    upd_index;
    dcache_pkg::block_t    upd_data;
    dcache_pkg::bstrb_t    upd_strb;

    dcache_reader reader (.*);

    dcache_writer writer (.*);

    dcache_blocks blocks (.*);

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
/* Testbench clock */

`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: sim/dcache_tb.sv
/* Data cache testbench */

`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    logic                 aclk;
    logic                 rst_n;
    logic                 rd_valid;
    logic                 rd_ready;
    dcache_pkg::addr_t    rd_addr;
    logic                 rsp_valid;
    logic                 rsp_ready;
    dcache_pkg::word_t    rsp_data;
    logic                 wr_valid;
    logic                 wr_ready;
    dcache_pkg::addr_t    wr_addr;
    dcache_pkg::word_t    wr_data;
    dcache_pkg::strb_t    wr_strb;
    logic                 wack_valid;
    logic                 wack_ready;
    logic                 mem_arvalid;
    logic                 mem_arready;
    dcache_pkg::addr_t    mem_araddr;
    logic                 mem_rvalid;
    logic                 mem_rready;
    dcache_pkg::block_t   mem_rdata;
    logic                 mem_awvalid;
    logic                 mem_awready;
    dcache_pkg::addr_t    mem_awaddr;
    dcache_pkg::word_t    mem_wdata;
    dcache_pkg::strb_t    mem_wstrb;
    logic                 mem_bvalid;
    logic                 mem_bready;

    // Operations from the pattern file
    logic [7:0]           op_list    [$];
    dcache_pkg::addr_t    addr_list  [$];
    dcache_pkg::word_t    data_list  [$];
    dcache_pkg::strb_t    strb_list  [$];
    dcache_pkg::word_t    exp_list   [$];
    int                   reads_list [$];
    int                   n_ops = 0;
    int                   ops_done = 0;

    // Word-addressed backing memory
    dcache_pkg::word_t    mem_words [0:16383];
    int                   block_reads = 0;

    int                   errors = 0;
    int                   checks = 0;
    logic [31:0]          rng = 32'h86a82394;

    clk_gen clock (.clk(aclk));

    dcache_top uut (.*);

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0 to 3 cycles
    function int rand_delay();
        rng = xorshift32(rng);
        return int'(rng[1:0]);
    endfunction

    // Ends 1 ns after a rising edge
    task automatic stall_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic dcache_pkg::block_t read_block(input dcache_pkg::addr_t a);
        return {mem_words[{a[15:4], 2'd3}], mem_words[{a[15:4], 2'd2}],
                mem_words[{a[15:4], 2'd1}], mem_words[{a[15:4], 2'd0}]};
    endfunction

    task automatic load_patterns();
        int                fd;
        int                n;
        int                r;
        string             line;
        logic [7:0]        op;
        dcache_pkg::addr_t a;
        dcache_pkg::word_t d;
        dcache_pkg::strb_t s;
        dcache_pkg::word_t e;
        fd = $fopen("sim/dcache_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file sim/dcache_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                // Skip comments and empty lines
                if (n > 1 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    n = $sscanf(line, "%c %h %h %h %h %d", op, a, d, s, e, r);
                    if (n == 6 && (op == "R" || op == "W")) begin
                        op_list.push_back(op);
                        addr_list.push_back(a);
                        data_list.push_back(d);
                        strb_list.push_back(s);
                        exp_list.push_back(e);
                        reads_list.push_back(r);
                    end else begin
                        $display("malformed line in the pattern file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (op_list.size() == 0) begin
                $display("the pattern file holds no operations");
                errors++;
            end
        end
        n_ops = op_list.size();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Core side operations
    //////////////////////////////////////////////////////////////////////

    task automatic issue_read(input dcache_pkg::addr_t addr, input dcache_pkg::word_t exp);
        rd_valid = 1'b1;
        rd_addr  = addr;
        do @(negedge aclk); while (!rd_ready);
        @(posedge aclk);
        #1;
        rd_valid = 1'b0;
        do @(negedge aclk); while (!rsp_valid);
        // Hold the response back for a while
        @(posedge aclk);
        #1;
        stall_cycles(rand_delay());
        rsp_ready = 1'b1;
        @(negedge aclk);
        compare_value("rsp_valid", 32'(rsp_valid), 32'd1);
        compare_value("rsp_data", rsp_data, exp);
        @(posedge aclk);
        #1;
        rsp_ready = 1'b0;
    endtask

    task automatic issue_write(input dcache_pkg::addr_t addr, input dcache_pkg::word_t data,
                               input dcache_pkg::strb_t strb, input dcache_pkg::word_t exp);
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        wr_strb  = strb;
        do @(negedge aclk); while (!wr_ready);
        @(posedge aclk);
        #1;
        wr_valid = 1'b0;
        do @(negedge aclk); while (!wack_valid);
        @(posedge aclk);
        #1;
        stall_cycles(rand_delay());
        wack_ready = 1'b1;
        @(negedge aclk);
        compare_value("wack_valid", 32'(wack_valid), 32'd1);
        @(posedge aclk);
        #1;
        wack_ready = 1'b0;
        // Memory holds the merged word once the write is acknowledged
        compare_value("memory word", mem_words[addr[15:2]], exp);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    initial begin : mem_read_model
        dcache_pkg::addr_t a;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(negedge aclk);
            if (mem_arvalid) begin
                @(posedge aclk);
                #1;
                stall_cycles(rand_delay());
                mem_arready = 1'b1;
                @(negedge aclk);
                a = mem_araddr;
                @(posedge aclk);
                #1;
                mem_arready = 1'b0;
                block_reads++;
                stall_cycles(rand_delay());
                mem_rvalid = 1'b1;
                mem_rdata  = read_block(a);
                do @(negedge aclk); while (!mem_rready);
                @(posedge aclk);
                #1;
                mem_rvalid = 1'b0;
            end
        end
    end

    initial begin : mem_write_model
        dcache_pkg::addr_t a;
        for (int w = 0; w < 16384; w++) begin
            mem_words[w[13:0]] = {w[15:0], ~w[15:0]};
        end
        mem_awready = 1'b0;
        mem_bvalid  = 1'b0;
        forever begin
            @(negedge aclk);
            if (mem_awvalid) begin
                @(posedge aclk);
                #1;
                stall_cycles(rand_delay());
                mem_awready = 1'b1;
                @(negedge aclk);
                a = mem_awaddr;
                for (int b = 0; b < 4; b++) begin
                    if (mem_wstrb[b]) begin
                        mem_words[a[15:2]][8*b +: 8] = mem_wdata[8*b +: 8];
                    end
                end
                @(posedge aclk);
                #1;
                mem_awready = 1'b0;
                stall_cycles(rand_delay());
                mem_bvalid = 1'b1;
                do @(negedge aclk); while (!mem_bready);
                @(posedge aclk);
                #1;
                mem_bvalid = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        rst_n      = 1'b0;
        rd_valid   = 1'b0;
        rd_addr    = '0;
        rsp_ready  = 1'b0;
        wr_valid   = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        wr_strb    = '0;
        wack_ready = 1'b0;
        load_patterns();
        repeat (4) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        @(negedge aclk);
        compare_value("rd_ready", 32'(rd_ready), 32'd1);
        compare_value("wr_ready", 32'(wr_ready), 32'd1);
        compare_value("rsp_valid", 32'(rsp_valid), 32'd0);
        compare_value("wack_valid", 32'(wack_valid), 32'd0);
        compare_value("mem_arvalid", 32'(mem_arvalid), 32'd0);
        compare_value("mem_awvalid", 32'(mem_awvalid), 32'd0);
        @(posedge aclk);
        #1;
        for (int i = 0; i < n_ops; i++) begin
            stall_cycles(rand_delay());
            if (op_list[i] == "W") begin
                issue_write(addr_list[i], data_list[i], strb_list[i], exp_list[i]);
            end else begin
                issue_read(addr_list[i], exp_list[i]);
            end
            compare_value("block read count", block_reads, reads_list[i]);
            ops_done++;
        end
        $display("%0d operations, %0d checks, %0d errors", ops_done, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Budget of 40 cycles per operation, plus reset
    initial begin : watchdog
        wait (n_ops > 0);
        repeat (n_ops * 40 + 8) @(posedge aclk);
        $display("watchdog timeout with %0d of %0d operations done, %0d errors",
                 ops_done, n_ops, errors);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/dcache_patterns.txt
# op addr wdata strb expected_data block_reads (hex except the last column, decimal)
# For W lines expected_data is the memory word after the write
R 0100 00000000 0 0040FFBF 1
R 0108 00000000 0 0042FFBD 1
R 010C 00000000 0 0043FFBC 1
R F000 00000000 0 3C00C3FF 2
R F000 00000000 0 3C00C3FF 3
R F004 00000000 0 3C01C3FE 4
W 0104 AABBCCDD 3 0041CCDD 4
R 0104 00000000 0 0041CCDD 4
W 0104 11223344 C 1122CCDD 4
R 0104 00000000 0 1122CCDD 4
W 0230 5A5A5A5A F 5A5A5A5A 4
R 0230 00000000 0 5A5A5A5A 5
R 0234 00000000 0 008DFF72 5
R 0330 00000000 0 00CCFF33 6
R 0230 00000000 0 5A5A5A5A 7
R 0338 00000000 0 00CEFF31 8
W F008 12345678 6 3C3456FD 8
R F008 00000000 0 3C3456FD 9
W 0100 000000EE 1 0040FFEE 9
R 0100 00000000 0 0040FFEE 9
R 010C 00000000 0 0043FFBC 9
R 1000 00000000 0 0400FBFF 10
R 0100 00000000 0 0040FFEE 11
R 0108 00000000 0 0042FFBD 11
R 2FFC 00000000 0 0BFFF400 12
R 2FF0 00000000 0 0BFCF403 12
W 2FF8 DEADBEEF F DEADBEEF 12
R 2FF8 00000000 0 DEADBEEF 12
W EFFC 77000000 8 77FFC400 12
R EFFC 00000000 0 77FFC400 13
R FFFC 00000000 0 3FFFC000 14
R 0104 00000000 0 1122CCDD 14

// File: src.f
design/dcache_pkg.sv
design/dcache_blocks.sv
design/dcache_reader.sv
design/dcache_writer.sv
design/dcache_top.sv
sim/clk_gen.sv
sim/dcache_tb.sv

// File: Makefile
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

SOURCES   := $(filter-out +%,$(shell cat src.f))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): src.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f src.f

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
